//--- files.f
hdl/display_pkg.sv
hdl/spi_byte_rx.sv
hdl/frame_loader.sv
hdl/vga_timing.sv
hdl/frame_ram.sv
hdl/frame_buffer.sv
hdl/pixel_out.sv
hdl/vga_spi_display.sv
verif/vga_spi_display_checker.sv
verif/tb_vga_spi_display.sv

//--- Makefile
TOP     = tb_vga_spi_display
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir $(OBJ_DIR) -f files.f

run: compile
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 2>&1 | tee $(LOG)
	@grep -q "^Simulation finished: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/tb_vga_spi_display.sv
`default_nettype none

module tb_vga_spi_display;

    timeunit 1ns;
    timeprecision 1ps;

    // ======================================================================
    // Configuration
    // ======================================================================

    localparam int RES_X     = 4;
    localparam int RES_Y     = 3;
    localparam int PIX_SCALE = 2;
    localparam int PIX_DIV   = 2;
    localparam int NPIX      = RES_X * RES_Y;

    localparam display_pkg::vga_timing_t TIMING = '{
        h_sync:   10'd2,
        h_back:   10'd2,
        h_active: 10'd8,
        h_front:  10'd2,
        v_sync:   10'd1,
        v_back:   10'd1,
        v_active: 10'd6,
        v_front:  10'd1
    };

    localparam int H_TOTAL   = int'(TIMING.h_sync) + int'(TIMING.h_back) +
                               int'(TIMING.h_active) + int'(TIMING.h_front);
    localparam int V_TOTAL   = int'(TIMING.v_sync) + int'(TIMING.v_back) +
                               int'(TIMING.v_active) + int'(TIMING.v_front);
    localparam int LINE_CLK  = H_TOTAL * PIX_DIV;
    localparam int FRAME_CLK = LINE_CLK * V_TOTAL;
    localparam int HSYNC_CLK = int'(TIMING.h_sync) * PIX_DIV;
    localparam int VSYNC_CLK = int'(TIMING.v_sync) * LINE_CLK;
    // clk from an hsync_n fall to the first active screen pixel
    localparam int ACT_OFS   = (int'(TIMING.h_sync) + int'(TIMING.h_back)) * PIX_DIV;
    localparam int ACT_CLK   = int'(TIMING.h_active) * PIX_DIV;
    localparam int ACT_LINE0 = int'(TIMING.v_sync) + int'(TIMING.v_back);
    localparam int ACT_LINES = int'(TIMING.v_active);

    localparam int          RESET_CYCLES = 10;
    localparam int          SCLK_HALF    = 3;
    localparam int unsigned SEED         = 32'hc039_419a;
    localparam int          NUM_ROWS     = 5;
    localparam int          MAX_BYTES    = 16;

    logic                   clk;
    logic                   rst;
    display_pkg::spi_pins_t spi;
    display_pkg::rgb_t      rgb;
    logic                   hsync_n;
    logic                   vsync_n;

    int errors;
    int tests;
    int failed;
    bit timed_out;

    // Test table, expected image filled in by the model
    string               row_name  [NUM_ROWS];
    display_pkg::pixel_t row_bytes [NUM_ROWS][MAX_BYTES];
    int                  row_len   [NUM_ROWS];
    bit                  row_swap  [NUM_ROWS];
    display_pkg::pixel_t row_image [NUM_ROWS][NPIX];

    display_pkg::pixel_t model_mem [2][NPIX];
    int                  model_back;
    int                  model_addr;

    vga_spi_display #(
        .RES_X     (RES_X),
        .RES_Y     (RES_Y),
        .PIX_SCALE (PIX_SCALE),
        .PIX_DIV   (PIX_DIV),
        .TIMING    (TIMING)
    ) i_dut (
        .clk     (clk),
        .rst     (rst),
        .spi     (spi),
        .rgb     (rgb),
        .hsync_n (hsync_n),
        .vsync_n (vsync_n)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_err);
        tests++;
        if (errors == start_err && !timed_out) begin
            $display("test %-28s ok", name);
        end else begin
            failed++;
            $display("test %-28s FAILED", name);
        end
    endtask

    function automatic logic sync_level(input bit vert);
        return vert ? vsync_n : hsync_n;
    endfunction

    task automatic wait_fall(input bit vert, input int limit, output bit ok);
        logic prev;
        logic cur;
        ok = 1'b0;
        prev = sync_level(vert);
        for (int i = 0; i < limit; i++) begin
            @(negedge clk);
            cur = sync_level(vert);
            if (prev && !cur) begin
                ok = 1'b1;
                break;
            end
            prev = cur;
        end
        if (!ok) begin
            $display("ERROR: %s did not fall within %0d clk cycles",
                     vert ? "vsync_n" : "hsync_n", limit);
            timed_out = 1'b1;
        end
    endtask

    // SPI byte, MSB first, cs_n raised afterwards
    task automatic send_byte(input display_pkg::pixel_t b);
        tick(1);
        spi.cs_n = 1'b0;
        for (int i = 7; i >= 0; i--) begin
            spi.mosi = b[i];
            tick(SCLK_HALF);
            spi.sclk = 1'b1;
            tick(SCLK_HALF);
            spi.sclk = 1'b0;
        end
        tick(SCLK_HALF);
        spi.cs_n = 1'b1;
        tick(SCLK_HALF);
    endtask

    // ======================================================================
    // Table and model
    // ======================================================================

    task automatic add_byte(input int r, input display_pkg::pixel_t b);
        row_bytes[r][row_len[r]] = b;
        row_len[r]++;
    endtask

    task automatic add_pixels(input int r, input int n);
        repeat (n) add_byte(r, 8'($urandom_range(63, 0)));
    endtask

    // Pixel bytes go to the back buffer, 0x81 swaps, other commands realign
    task automatic model_row(input int r);
        bit                  swap;
        display_pkg::pixel_t b;
        swap = 1'b0;
        for (int i = 0; i < row_len[r]; i++) begin
            b = row_bytes[r][i];
            if (b == 8'h81) begin
                swap = 1'b1;
            end else if (b[7]) begin
                model_addr = 0;
            end else begin
                model_mem[model_back][model_addr] = b;
                model_addr = (model_addr == NPIX - 1) ? 0 : model_addr + 1;
            end
        end
        row_swap[r] = swap;
        if (swap) begin
            model_back = 1 - model_back;
        end
        for (int i = 0; i < NPIX; i++) begin
            row_image[r][i] = model_mem[1 - model_back][i];
        end
    endtask

    task automatic build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            row_len[r] = 0;
        end
        row_name[0] = "write and swap";
        add_pixels(0, NPIX);
        add_byte(0, 8'h81);
        row_name[1] = "no swap";
        add_pixels(1, NPIX);
        row_name[2] = "swap after no swap";
        add_byte(2, 8'h81);
        row_name[3] = "align and unknown command";
        add_pixels(3, 5);
        add_byte(3, 8'h80);
        add_pixels(3, 3);
        add_byte(3, 8'h9F);
        add_pixels(3, 2);
        add_byte(3, 8'h81);
        row_name[4] = "address wrap";
        add_byte(4, 8'h80);
        add_pixels(4, NPIX + 1);
        add_byte(4, 8'h81);
        model_back = 0;
        model_addr = 0;
        for (int i = 0; i < NPIX; i++) begin
            model_mem[0][i] = '0;
            model_mem[1][i] = '0;
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            model_row(r);
        end
    endtask

    // ======================================================================
    // Checks
    // ======================================================================

    task automatic check_reset();
        int start_err;
        start_err = errors;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_value("rgb", rgb, '0);
            check_value("wr_en", i_dut.wr_en, '0);
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            check_value("rgb", rgb, '0);
            check_value("wr_en", i_dut.wr_en, '0);
        end
        report_test("reset", start_err);
    endtask

    task automatic measure_sync(input bit vert, input int exp_low, input int exp_period);
        bit ok;
        bit seen_high;
        int low_len;
        int period;
        wait_fall(vert, 2 * exp_period, ok);
        if (!ok) begin
            return;
        end
        seen_high = 1'b0;
        low_len = 0;
        period = 0;
        while (period < 2 * exp_period) begin
            if (sync_level(vert)) begin
                seen_high = 1'b1;
            end else if (seen_high) begin
                break;
            end else begin
                low_len++;
            end
            @(negedge clk);
            period++;
        end
        if (period >= 2 * exp_period) begin
            $display("ERROR: sync pulse did not repeat within %0d clk cycles", period);
            timed_out = 1'b1;
            return;
        end
        check_value(vert ? "vsync_n low clk" : "hsync_n low clk", low_len, exp_low);
        check_value(vert ? "vsync_n period" : "hsync_n period", period, exp_period);
    endtask

    function automatic display_pkg::rgb_t expected_rgb(input int r, input int line, input int k);
        display_pkg::rgb_t   exp;
        display_pkg::pixel_t p;
        int                  sx;
        int                  sy;
        exp = '0;
        if (line >= ACT_LINE0 && line < ACT_LINE0 + ACT_LINES &&
            k >= ACT_OFS && k < ACT_OFS + ACT_CLK) begin
            sx = (k - ACT_OFS) / PIX_DIV;
            sy = line - ACT_LINE0;
            p = row_image[r][(sy / PIX_SCALE) * RES_X + sx / PIX_SCALE];
            exp.red   = {p[5:4], 2'b00};
            exp.green = {p[3:2], 2'b00};
            exp.blue  = {p[1:0], 2'b00};
        end
        return exp;
    endfunction

    // Second vsync fall starts a frame with any pending swap applied
    task automatic check_frame(input int r);
        bit ok;
        wait_fall(1'b1, 2 * FRAME_CLK, ok);
        if (ok) begin
            wait_fall(1'b1, 2 * FRAME_CLK, ok);
        end
        for (int line = 0; line < V_TOTAL && ok; line++) begin
            // hsync_n falls together with vsync_n on line 0
            if (line > 0) begin
                wait_fall(1'b0, 2 * LINE_CLK, ok);
            end
            for (int k = 0; k < ACT_OFS + ACT_CLK && ok; k++) begin
                if (k > 0) begin
                    @(negedge clk);
                end
                check_value($sformatf("rgb (line %0d, clk %0d)", line, k), rgb,
                            expected_rgb(r, line, k));
            end
        end
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        int start_err;
        int checker_fails;
        rst = 1'b1;
        spi.sclk = 1'b0;
        spi.cs_n = 1'b1;
        spi.mosi = 1'b0;
        errors = 0;
        tests = 0;
        failed = 0;
        timed_out = 1'b0;
        void'($urandom(SEED));
        build_table();

        check_reset();

        start_err = errors;
        measure_sync(1'b0, HSYNC_CLK, LINE_CLK);
        if (!timed_out) begin
            measure_sync(1'b1, VSYNC_CLK, FRAME_CLK);
        end
        report_test("sync timing", start_err);

        for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
            start_err = errors;
            for (int i = 0; i < row_len[r]; i++) begin
                send_byte(row_bytes[r][i]);
            end
            // Receiver and loader latency after the last byte
            tick(8);
            check_frame(r);
            report_test($sformatf("%s%s", row_name[r], row_swap[r] ? " (swap)" : ""),
                        start_err);
        end

        checker_fails = i_dut.u_checker.blank_fails + i_dut.u_checker.swap_fails +
                        i_dut.u_checker.addr_fails;
        if (checker_fails != 0) begin
            $display("ERROR: %0d bound assertion failures", checker_fails);
        end
        $display("Summary: %0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 tests, failed, errors, checker_fails);
        if (errors == 0 && failed == 0 && checker_fails == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/vga_spi_display_checker.sv
`default_nettype none

module vga_spi_display_checker #(
    parameter int RES_X = 320,
    parameter int RES_Y = 240
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           scan_active,
    input  display_pkg::rgb_t              rgb,
    input  logic                           swap_req,
    input  logic [display_pkg::ADDR_W-1:0] wr_addr
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [display_pkg::ADDR_W-1:0] FRAME_PIXELS =
        display_pkg::ADDR_W'(RES_X * RES_Y);

    // Failure counts per property
    int blank_fails = 0;
    int swap_fails  = 0;
    int addr_fails  = 0;

    // rgb trails the scan by two clk, the RAM read plus the output register
    blank_rgb: assert property (@(posedge clk) disable iff (rst)
                                !scan_active |-> ##2 rgb == '0)
        else begin
            blank_fails++;
            $error("rgb not blanked two clk after an inactive scan position");
        end

    single_swap: assert property (@(posedge clk) disable iff (rst) swap_req |=> !swap_req)
        else begin
            swap_fails++;
            $error("swap_req high for two cycles in a row");
        end

    addr_range: assert property (@(posedge clk) disable iff (rst) wr_addr < FRAME_PIXELS)
        else begin
            addr_fails++;
            $error("wr_addr outside the frame");
        end

endmodule

bind vga_spi_display vga_spi_display_checker #(
    .RES_X (RES_X),
    .RES_Y (RES_Y)
) u_checker (
    .clk         (clk),
    .rst         (rst),
    .scan_active (scan.active),
    .rgb         (rgb),
    .swap_req    (swap_req),
    .wr_addr     (wr_addr)
);

`default_nettype wire

//--- hdl/vga_spi_display.sv
`default_nettype none

module vga_spi_display #(
    parameter int                       RES_X     = 320,
    parameter int                       RES_Y     = 240,
    parameter int                       PIX_SCALE = 2,
    parameter int                       PIX_DIV   = 2,
    parameter display_pkg::vga_timing_t TIMING    = display_pkg::VGA_640X480
) (
    input  logic                   clk,
    input  logic                   rst,
    input  display_pkg::spi_pins_t spi,
    output display_pkg::rgb_t      rgb,
    output logic                   hsync_n,
    output logic                   vsync_n
);

    // ======================================================================
    // Interconnect
    // ======================================================================

    logic                           rx_valid;
    display_pkg::pixel_t            rx_byte;
    logic                           wr_en;
    logic [display_pkg::ADDR_W-1:0] wr_addr;
    display_pkg::pixel_t            wr_pixel;
    logic                           swap_req;
    display_pkg::scan_t             scan;
    logic                           frame_start;
    display_pkg::pixel_t            rd_pixel;

    // Write side
    spi_byte_rx u_spi_rx (
        .clk      (clk),
        .rst      (rst),
        .spi      (spi),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    frame_loader #(.RES_X(RES_X), .RES_Y(RES_Y)) u_loader (
        .clk      (clk),
        .rst      (rst),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_pixel (wr_pixel),
        .swap_req (swap_req)
    );

    // Display side
    vga_timing #(.PIX_DIV(PIX_DIV), .TIMING(TIMING)) u_timing (
        .clk         (clk),
        .rst         (rst),
        .scan        (scan),
        .frame_start (frame_start)
    );

    frame_buffer #(.RES_X(RES_X), .RES_Y(RES_Y), .PIX_SCALE(PIX_SCALE)) u_buffer (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_pixel    (wr_pixel),
        .swap_req    (swap_req),
        .scan        (scan),
        .frame_start (frame_start),
        .rd_pixel    (rd_pixel)
    );

    pixel_out u_pixel_out (
        .clk      (clk),
        .rst      (rst),
        .scan     (scan),
        .rd_pixel (rd_pixel),
        .rgb      (rgb),
        .hsync_n  (hsync_n),
        .vsync_n  (vsync_n)
    );

endmodule

`default_nettype wire

//--- hdl/pixel_out.sv
`default_nettype none

module pixel_out (
    input  logic                clk,
    input  logic                rst,
    input  display_pkg::scan_t  scan,
    input  display_pkg::pixel_t rd_pixel,
    output display_pkg::rgb_t   rgb,
    output logic                hsync_n,
    output logic                vsync_n
);

    // Scan flags delayed to line up with RAM data
    logic active_d;
    logic hsync_d;
    logic vsync_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_d <= 1'b0;
            hsync_d  <= 1'b0;
            vsync_d  <= 1'b0;
            rgb      <= '0;
            hsync_n  <= 1'b0;
            vsync_n  <= 1'b0;
        end else begin
            active_d <= scan.active;
            hsync_d  <= scan.hsync_n;
            vsync_d  <= scan.vsync_n;
            hsync_n  <= hsync_d;
            vsync_n  <= vsync_d;
            if (active_d) begin
                // 2-bit channels into the top of the 4-bit DAC
                rgb.red   <= {rd_pixel[5:4], 2'b00};
                rgb.green <= {rd_pixel[3:2], 2'b00};
                rgb.blue  <= {rd_pixel[1:0], 2'b00};
            end else begin
                rgb <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/frame_buffer.sv
`default_nettype none

module frame_buffer #(
    parameter int RES_X     = 320,
    parameter int RES_Y     = 240,
    parameter int PIX_SCALE = 2
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr_en,
    input  logic [display_pkg::ADDR_W-1:0] wr_addr,
    input  display_pkg::pixel_t            wr_pixel,
    input  logic                           swap_req,
    input  display_pkg::scan_t             scan,
    input  logic                           frame_start,
    output display_pkg::pixel_t            rd_pixel
);

    localparam int AW = display_pkg::ADDR_W;

    logic                back_sel;
    logic                back_sel_q;
    logic                swap_pend;
    logic [AW-1:0]       rd_addr;
    display_pkg::pixel_t rd0;
    display_pkg::pixel_t rd1;

    // Stored pixel under the beam
    assign rd_addr = AW'(scan.y / PIX_SCALE) * AW'(RES_X) + AW'(scan.x / PIX_SCALE);

    // Swap only between frames so a frame is never torn
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            back_sel   <= 1'b0;
            back_sel_q <= 1'b0;
            swap_pend  <= 1'b0;
        end else begin
            back_sel_q <= back_sel;
            if (frame_start && swap_pend) begin
                back_sel  <= ~back_sel;
                swap_pend <= swap_req;
            end else if (swap_req) begin
                swap_pend <= 1'b1;
            end
        end
    end

    frame_ram #(.DEPTH(RES_X * RES_Y)) u_ram0 (
        .clk      (clk),
        .wr_en    (wr_en && !back_sel),
        .wr_addr  (wr_addr),
        .wr_pixel (wr_pixel),
        .rd_addr  (rd_addr),
        .rd_pixel (rd0)
    );

    frame_ram #(.DEPTH(RES_X * RES_Y)) u_ram1 (
        .clk      (clk),
        .wr_en    (wr_en && back_sel),
        .wr_addr  (wr_addr),
        .wr_pixel (wr_pixel),
        .rd_addr  (rd_addr),
        .rd_pixel (rd1)
    );

    // Select matches the cycle the read was issued
    assign rd_pixel = back_sel_q ? rd0 : rd1;

endmodule

`default_nettype wire

//--- hdl/frame_ram.sv
`default_nettype none

module frame_ram #(
    parameter int DEPTH = 320 * 240
) (
    input  logic                           clk,
    input  logic                           wr_en,
    input  logic [display_pkg::ADDR_W-1:0] wr_addr,
    input  display_pkg::pixel_t            wr_pixel,
    input  logic [display_pkg::ADDR_W-1:0] rd_addr,
    output display_pkg::pixel_t            rd_pixel
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    display_pkg::pixel_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[AW-1:0]] <= wr_pixel;
        end
        rd_pixel <= mem[rd_addr[AW-1:0]];
    end

endmodule

`default_nettype wire

//--- hdl/vga_timing.sv
`default_nettype none

module vga_timing #(
    parameter int                       PIX_DIV = 2,
    parameter display_pkg::vga_timing_t TIMING  = display_pkg::VGA_640X480
) (
    input  logic                clk,
    input  logic                rst,
    output display_pkg::scan_t  scan,
    output logic                frame_start
);

    localparam int DIV_W = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(PIX_DIV - 1);

    localparam logic [9:0] H_ACT0 = TIMING.h_sync + TIMING.h_back;
    localparam logic [9:0] H_ACT1 = H_ACT0 + TIMING.h_active;
    localparam logic [9:0] H_LAST = H_ACT1 + TIMING.h_front - 10'd1;
    localparam logic [9:0] V_ACT0 = TIMING.v_sync + TIMING.v_back;
    localparam logic [9:0] V_ACT1 = V_ACT0 + TIMING.v_active;
    localparam logic [9:0] V_LAST = V_ACT1 + TIMING.v_front - 10'd1;

    logic [DIV_W-1:0] div_cnt;
    logic             pix_en;
    logic [9:0]       h_cnt;
    logic [9:0]       v_cnt;
    logic             active;

    // Last clk of each screen pixel
    assign pix_en = (div_cnt == DIV_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end else begin
            div_cnt <= pix_en ? '0 : div_cnt + 1'b1;
            if (pix_en) begin
                if (h_cnt == H_LAST) begin
                    h_cnt <= '0;
                    v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 10'd1;
                end else begin
                    h_cnt <= h_cnt + 10'd1;
                end
            end
        end
    end

    assign active = (h_cnt >= H_ACT0) && (h_cnt < H_ACT1) &&
                    (v_cnt >= V_ACT0) && (v_cnt < V_ACT1);

    assign scan.active  = active;
    assign scan.x       = active ? h_cnt - H_ACT0 : '0;
    assign scan.y       = active ? v_cnt - V_ACT0 : '0;
    assign scan.hsync_n = (h_cnt >= TIMING.h_sync);
    assign scan.vsync_n = (v_cnt >= TIMING.v_sync);

    assign frame_start = (h_cnt == '0) && (v_cnt == '0) && (div_cnt == '0);

endmodule

`default_nettype wire

//--- hdl/frame_loader.sv
`default_nettype none

module frame_loader #(
    parameter int RES_X = 320,
    parameter int RES_Y = 240
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rx_valid,
    input  display_pkg::pixel_t               rx_byte,
    output logic                              wr_en,
    output logic [display_pkg::ADDR_W-1:0]    wr_addr,
    output display_pkg::pixel_t               wr_pixel,
    output logic                              swap_req
);

    localparam int AW = display_pkg::ADDR_W;
    localparam logic [AW-1:0] LAST_ADDR = AW'(RES_X * RES_Y - 1);

    // Address of the next pixel byte
    logic [AW-1:0] addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr     <= '0;
            wr_addr  <= '0;
            wr_en    <= 1'b0;
            swap_req <= 1'b0;
        end else begin
            wr_en    <= 1'b0;
            swap_req <= 1'b0;
            if (rx_valid) begin
                if (rx_byte[display_pkg::CMD_BIT]) begin
                    case (rx_byte[display_pkg::CMD_BIT-1:0])
                        display_pkg::CMD_ALIGN: addr <= '0;
                        display_pkg::CMD_SWAP:  swap_req <= 1'b1;
                        // Unknown commands realign as well
                        default:                addr <= '0;
                    endcase
                end else begin
                    wr_en   <= 1'b1;
                    wr_addr <= addr;
                    addr    <= (addr == LAST_ADDR) ? '0 : addr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && !rx_byte[display_pkg::CMD_BIT]) begin
            wr_pixel <= rx_byte;
        end
    end

endmodule

`default_nettype wire

//--- hdl/spi_byte_rx.sv
`default_nettype none

module spi_byte_rx (
    input  logic                  clk,
    input  logic                  rst,
    input  display_pkg::spi_pins_t spi,
    output logic                  rx_valid,
    output display_pkg::pixel_t   rx_byte
);

    // ======================================================================
    // sclk domain
    // ======================================================================

    logic                sclk;
    logic                cnt_clr;
    logic [2:0]          bit_cnt;
    logic [6:0]          shift_q;
    display_pkg::pixel_t next_byte;
    display_pkg::pixel_t captured;
    logic                byte_tog;

    assign sclk      = spi.sclk;
    assign next_byte = {shift_q, spi.mosi};

    // Deselect restarts the byte framing
    assign cnt_clr = rst | spi.cs_n;

    always_ff @(posedge sclk or posedge cnt_clr) begin
        if (cnt_clr) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    // MSB first
    always_ff @(posedge sclk) begin
        if (!spi.cs_n) begin
            shift_q <= next_byte[6:0];
            if (bit_cnt == 3'd7) begin
                captured <= next_byte;
            end
        end
    end

    always_ff @(posedge sclk or posedge rst) begin
        if (rst) begin
            byte_tog <= 1'b0;
        end else if (!spi.cs_n && bit_cnt == 3'd7) begin
            byte_tog <= ~byte_tog;
        end
    end

    // ======================================================================
    // Crossing into clk
    // ======================================================================

    logic                tog_s1;
    logic                tog_s2;
    logic                tog_s3;
    display_pkg::pixel_t byte_s1;
    display_pkg::pixel_t byte_s2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tog_s1   <= 1'b0;
            tog_s2   <= 1'b0;
            tog_s3   <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            tog_s1   <= byte_tog;
            tog_s2   <= tog_s1;
            tog_s3   <= tog_s2;
            rx_valid <= tog_s2 ^ tog_s3;
        end
    end

    // Captured byte has long settled by the time the toggle edge is seen
    always_ff @(posedge clk) begin
        byte_s1 <= captured;
        byte_s2 <= byte_s1;
        if (tog_s2 ^ tog_s3) begin
            rx_byte <= byte_s2;
        end
    end

endmodule

`default_nettype wire

//--- hdl/display_pkg.sv
`default_nettype none

package display_pkg;

    // ======================================================================
    // Pixel and colour types
    // ======================================================================

    // Stored pixel, 0b00RRGGBB
    typedef logic [7:0] pixel_t;

    // One VGA DAC channel
    typedef logic [3:0] color_t;

    typedef struct packed {
        color_t red;
        color_t green;
        color_t blue;
    } rgb_t;

    typedef struct packed {
        logic sclk;
        logic cs_n;
        logic mosi;
    } spi_pins_t;

    // ======================================================================
    // Video timing
    // ======================================================================

    // Counts in screen pixels (h) and lines (v), each phase in scan order
    typedef struct packed {
        logic [9:0] h_sync;
        logic [9:0] h_back;
        logic [9:0] h_active;
        logic [9:0] h_front;
        logic [9:0] v_sync;
        logic [9:0] v_back;
        logic [9:0] v_active;
        logic [9:0] v_front;
    } vga_timing_t;

    localparam vga_timing_t VGA_640X480 = '{
        h_sync:   10'd96,
        h_back:   10'd48,
        h_active: 10'd640,
        h_front:  10'd16,
        v_sync:   10'd2,
        v_back:   10'd33,
        v_active: 10'd480,
        v_front:  10'd10
    };

    // Scan position, x and y relative to the active window
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       active;
        logic       hsync_n;
        logic       vsync_n;
    } scan_t;

    // ======================================================================
    // Command bytes
    // ======================================================================

    localparam int CMD_BIT = 7;

    // Codes in the low seven bits of a control byte
    localparam logic [6:0] CMD_ALIGN = 7'h00;
    localparam logic [6:0] CMD_SWAP  = 7'h01;

    // Enough for 320x240
    localparam int ADDR_W = 17;

endpackage

`default_nettype wire
